/* dv/ivmu_tb.sv */
// Self-checking testbench for the interrupt vector unit, run as the simulation top with the file list
`timescale 1ns/10ps

module ivmu_tb
    import ivmu_pkg::*;
();

    // Cycles allowed for ack to move before a bus timeout
    localparam int BUS_LIMIT = 20;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              req;
    logic              wr;
    logic [ADDR_W-1:0] addr;
    vec_t              wdata;
    logic              ack;
    vec_t              rdata;
    irq_t              irq_sources;
    vec_t              irq_vector;
    logic              irq_valid;

    // Reference copy of the software-visible configuration
    vec_t model_table [IRQ_COUNT];
    irq_t model_mask;

    // Source and mask history, newest first
    // Two captured patterns plus the expected register span the three DUT stages
    irq_t src_hist  [2];
    irq_t mask_hist [2];
    vec_t exp_vec;
    logic exp_valid;
    int   fill;
    int   quiet;
    logic check_en;

    logic [31:0] lcg_state = 32'hf1a7_bcb6;
    int errors      = 0;
    int errors_mark = 0;
    int tests_ok    = 0;
    int tests_bad   = 0;
    int test_no     = 1;

    ivmu_top ivmu_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .wr          (wr),
        .addr        (addr),
        .wdata       (wdata),
        .ack         (ack),
        .rdata       (rdata),
        .irq_sources (irq_sources),
        .irq_vector  (irq_vector),
        .irq_valid   (irq_valid)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Highest pending source wins, no source gives zero
    function automatic vec_t expected_vector(input irq_t pend);
        vec_t v;
        logic found;
        v = '0;
        found = 1'b0;
        for (int i = IRQ_COUNT - 1; i >= 0; i--) begin
            if (pend[i] && !found) begin
                v = model_table[i];
                found = 1'b1;
            end
        end
        return v;
    endfunction

    task automatic report_err(input string name, input vec_t exp, input vec_t act);
        errors++;
        $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    // Prediction pipeline, two patterns of history ahead of the expected output
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2; i++) begin
                src_hist[i]  <= '0;
                mask_hist[i] <= '0;
            end
            exp_vec   <= '0;
            exp_valid <= 1'b0;
            fill      <= 0;
            quiet     <= 0;
        end else begin
            src_hist[0]  <= irq_sources;
            src_hist[1]  <= src_hist[0];
            mask_hist[0] <= model_mask;
            mask_hist[1] <= mask_hist[0];
            exp_vec      <= expected_vector(src_hist[1] & ~mask_hist[1]);
            exp_valid    <= |(src_hist[1] & ~mask_hist[1]);
            if (fill < 4) begin
                fill <= fill + 1;
            end
            // Any write restarts the settle count
            if (req && wr) begin
                quiet <= 0;
            end else if (quiet < 8) begin
                quiet <= quiet + 1;
            end
        end
    end

    assign check_en = (fill == 4) && (quiet >= 7);

    // Interrupt outputs against the model
    assert property (@(posedge clk) disable iff (!rst_n) check_en |-> irq_vector == exp_vec)
        else report_err("irq_vector", $sampled(exp_vec), $sampled(irq_vector));
    assert property (@(posedge clk) disable iff (!rst_n) check_en |-> irq_valid == exp_valid)
        else report_err("irq_valid", VEC_W'($sampled(exp_valid)), VEC_W'($sampled(irq_valid)));

    // Four-phase handshake rules
    assert property (@(posedge clk) disable iff (!rst_n) !req && !ack |=> !ack)
        else note_failure("ack rose while req was low");
    assert property (@(posedge clk) disable iff (!rst_n) req && ack |=> ack)
        else note_failure("ack fell while req was still high");
    assert property (@(posedge clk) disable iff (!rst_n) ack |=> $stable(rdata))
        else note_failure("rdata changed while ack was high");

    task automatic check_word(input string name, input vec_t exp, input vec_t got);
        assert (got === exp) else report_err(name, exp, got);
    endtask

    // One full req/ack transaction, the host sometimes holds req after ack
    task automatic bus_xfer(input logic is_wr, input logic [ADDR_W-1:0] a, input vec_t d,
                            output vec_t got);
        int n;
        int hold;
        @(posedge clk);
        req   <= 1'b1;
        wr    <= is_wr;
        addr  <= a;
        wdata <= d;
        n = 0;
        @(posedge clk);
        while (ack !== 1'b1 && n < BUS_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (ack !== 1'b1) begin
            note_failure($sformatf("ack never rose for address %0d", a));
        end
        got = rdata;
        hold = int'(next_rand() % 32'd3);
        repeat (hold) @(posedge clk);
        req <= 1'b0;
        n = 0;
        @(posedge clk);
        while (ack !== 1'b0 && n < BUS_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (ack !== 1'b0) begin
            note_failure($sformatf("ack never fell for address %0d", a));
        end
        if (is_wr) begin
            if (a < IRQ_COUNT) begin
                model_table[a] <= d;
            end else if (a == CSR_MASK_ADDR) begin
                model_mask <= d[IRQ_COUNT-1:0];
            end
        end
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] a, input vec_t d);
        vec_t unused;
        bus_xfer(1'b1, a, d, unused);
    endtask

    task automatic read_check(input logic [ADDR_W-1:0] a, input vec_t exp);
        vec_t got;
        bus_xfer(1'b0, a, '0, got);
        check_word($sformatf("rdata[addr %0d]", a), exp, got);
    endtask

    // Mix of zero, held, lower-half-only and full patterns
    task automatic drive_random_sources(input int cycles);
        logic [31:0] r;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            r = next_rand();
            if (r[2:0] == 3'd0) begin
                irq_sources <= '0;
            end else if (r[4:3] == 2'd0) begin
                // Hold the previous pattern
                irq_sources <= irq_sources;
            end else if (r[6:5] == 2'd0) begin
                irq_sources <= r[31:16] & 16'h00ff;
            end else begin
                irq_sources <= r[31:16];
            end
        end
    endtask

    task automatic close_test(input string label);
        // Let in-flight patterns drain through the checks
        repeat (6) @(posedge clk);
        if (errors == errors_mark) begin
            tests_ok++;
            $display("[%0t] test %0d %s: ok", $time, test_no, label);
        end else begin
            tests_bad++;
            $display("[%0t] test %0d %s: %0d errors", $time, test_no, label,
                     errors - errors_mark);
        end
        test_no++;
        errors_mark = errors;
    endtask

    initial begin
        irq_t pat;
        vec_t word;
        rst_n       <= 1'b0;
        req         <= 1'b0;
        wr          <= 1'b0;
        addr        <= '0;
        wdata       <= '0;
        irq_sources <= '0;
        model_mask  <= '0;
        for (int i = 0; i < IRQ_COUNT; i++) begin
            model_table[i] <= '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Reset state
        @(negedge clk);
        check_word("ack", 32'd0, VEC_W'(ack));
        check_word("irq_valid", 32'd0, VEC_W'(irq_valid));
        check_word("irq_vector", 32'd0, irq_vector);
        for (int a = 0; a <= CSR_STATUS_ADDR; a++) begin
            read_check(a, '0);
        end
        close_test("reset values");

        // Register read-back and the unmapped and read-only addresses
        for (int a = 0; a < IRQ_COUNT; a++) begin
            write_reg(a, next_rand());
        end
        write_reg(CSR_MASK_ADDR, next_rand() & 32'h0000_ffff);
        for (int a = 0; a < IRQ_COUNT; a++) begin
            read_check(a, model_table[a]);
        end
        read_check(CSR_MASK_ADDR, VEC_W'(model_mask));
        read_check(8'd200, '0);
        pat = next_rand();
        irq_sources <= pat;
        repeat (3) @(posedge clk);
        read_check(CSR_STATUS_ADDR, VEC_W'(pat & ~model_mask));
        write_reg(CSR_STATUS_ADDR, next_rand());
        read_check(CSR_STATUS_ADDR, VEC_W'(pat & ~model_mask));
        close_test("register access");

        // Unmasked priority path, several patterns in flight
        write_reg(CSR_MASK_ADDR, '0);
        drive_random_sources(150);
        close_test("priority without mask");

        // Random mask, then everything masked
        write_reg(CSR_MASK_ADDR, next_rand() & 32'h0000_ffff);
        drive_random_sources(120);
        write_reg(CSR_MASK_ADDR, 32'h0000_ffff);
        drive_random_sources(60);
        close_test("priority with mask");

        // Status follows held sources through the mask
        for (int k = 0; k < 4; k++) begin
            write_reg(CSR_MASK_ADDR, next_rand() & 32'h0000_ffff);
            pat = next_rand();
            irq_sources <= pat;
            repeat (3) @(posedge clk);
            read_check(CSR_STATUS_ADDR, VEC_W'(pat & ~model_mask));
        end
        close_test("status register");

        // Mixed traffic keeps the handshake checks busy
        for (int k = 0; k < 12; k++) begin
            word = next_rand();
            write_reg(k, word);
            read_check(k, word);
        end
        close_test("handshake rules");

        $display("Summary: %0d tests ok, %0d tests bad, %0d errors", tests_ok, tests_bad,
                 errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* ivmu.f */
verilog/ivmu_pkg.sv
verilog/ivmu_half_if.sv
verilog/ivmu_csr_bank.sv
verilog/ivmu_prio_stage.sv
verilog/ivmu_select_stage.sv
verilog/ivmu_top.sv
dv/ivmu_tb.sv

/* verilog/ivmu_csr_bank.sv */
// Register bus slave holding the vector table, mask and status, answering four-phase req/ack
`timescale 1ns/10ps

module ivmu_csr_bank
    import ivmu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // Host side of the register bus
    input  logic              req,
    input  logic              wr,
    input  logic [ADDR_W-1:0] addr,
    input  vec_t              wdata,
    output logic              ack,
    output vec_t              rdata,
    // Masked pattern from the priority stage, sampled into status
    input  irq_t              irq_masked,
    // Configuration handed to the interrupt path
    output vec_table_t        vec_table,
    output irq_t              irq_mask
);

    // Status copy of the masked pattern, one cycle behind
    irq_t status;

    // Decoded read data for the current address
    vec_t rd_mux;

    // Address falls into the vector table range
    logic in_table;

    assign in_table = (addr < ADDR_W'(IRQ_COUNT));

    // Read decode over the full address
    // Anything outside the map reads zero
    always_comb begin
        if (in_table) begin
            rd_mux = vec_table[addr[$clog2(IRQ_COUNT)-1:0]];
        end else if (addr == CSR_MASK_ADDR) begin
            rd_mux = VEC_W'(irq_mask);
        end else if (addr == CSR_STATUS_ADDR) begin
            rd_mux = VEC_W'(status);
        end else begin
            rd_mux = '0;
        end
    end

    // Handshake state is the ack flop itself
    // Low means idle, high means a transaction waits for req to drop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else if (!ack && req) begin
            // Accept on the first edge that sees req
            ack <= 1'b1;
        end else if (ack && !req) begin
            // Host has let go, close the transaction
            ack <= 1'b0;
        end
    end

    // Register writes and read capture happen on the accepting edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vec_table <= '0;
            irq_mask  <= '0;
            rdata     <= '0;
        end else if (!ack && req) begin
            if (wr) begin
                if (in_table) begin
                    vec_table[addr[$clog2(IRQ_COUNT)-1:0]] <= wdata;
                end else if (addr == CSR_MASK_ADDR) begin
                    // Only the low bits carry mask state
                    irq_mask <= wdata[IRQ_COUNT-1:0];
                end
                // Status and unmapped addresses drop the write
            end else begin
                // Held until the next read, so stable while ack is high
                rdata <= rd_mux;
            end
        end
    end

    // Status tracks the masked pattern on every edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status <= '0;
        end else begin
            status <= irq_masked;
        end
    end

endmodule

/* verilog/ivmu_half_if.sv */
// Per-half priority results passed from the encode stage to the final select stage
`timescale 1ns/10ps

interface ivmu_half_if
    import ivmu_pkg::*;
();

    // Winning vector of each half
    vec_t vec_hi;
    vec_t vec_lo;

    // Some unmasked source is pending in the half
    logic valid_hi;
    logic valid_lo;

    // Priority stage drives the registered results
    modport src (
        output vec_hi, vec_lo, valid_hi, valid_lo
    );

    // Select stage only reads them, no handshake since it moves every cycle
    modport dst (
        input vec_hi, vec_lo, valid_hi, valid_lo
    );

endinterface

/* verilog/ivmu_pkg.sv */
// Shared sizes, register map and data types of the interrupt vector unit, imported by every block
package ivmu_pkg;

    // Source count and split into two priority halves
    localparam int IRQ_COUNT = 16;
    localparam int IRQ_HALF  = 8;

    // Vector width, also the register word width
    localparam int VEC_W = 32;

    // Register bus address width, decoded in full
    localparam int ADDR_W = 8;

    // Register map
    // Addresses below IRQ_COUNT select a vector table entry
    localparam logic [ADDR_W-1:0] CSR_MASK_ADDR   = 8'd16;
    localparam logic [ADDR_W-1:0] CSR_STATUS_ADDR = 8'd17;

    // One vector or one register word
    typedef logic [VEC_W-1:0] vec_t;

    // Source, mask or status pattern, bit i is source i
    typedef logic [IRQ_COUNT-1:0] irq_t;

    // Whole vector table packed together, entry i belongs to source i
    typedef logic [IRQ_COUNT-1:0][VEC_W-1:0] vec_table_t;

endpackage

/* verilog/ivmu_prio_stage.sv */
// Interrupt pipeline stages 1 and 2: mask and capture sources, then encode each half
`timescale 1ns/10ps

module ivmu_prio_stage
    import ivmu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  irq_t       irq_sources,
    input  irq_t       irq_mask,
    input  vec_table_t vec_table,
    // Stage 1 register, also feeds the status register
    output irq_t       irq_masked,
    ivmu_half_if.src   half
);

    // Combinational encoder outputs ahead of the stage 2 register
    vec_t enc_vec_hi;
    vec_t enc_vec_lo;

    // Highest set bit of a half picks its table entry
    // Zero when no bit is set
    function automatic vec_t encode_half(
        input logic [IRQ_HALF-1:0]            bits,
        input logic [IRQ_HALF-1:0][VEC_W-1:0] entries
    );
        vec_t sel;
        sel = '0;
        // Later iterations overwrite earlier ones, so the top bit wins
        for (int i = 0; i < IRQ_HALF; i++) begin
            if (bits[i]) begin
                sel = entries[i];
            end
        end
        return sel;
    endfunction

    // Stage 1, masked bits cleared before capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_masked <= '0;
        end else begin
            irq_masked <= irq_sources & ~irq_mask;
        end
    end

    // Each half uses its own slice of the table
    assign enc_vec_hi = encode_half(irq_masked[IRQ_COUNT-1:IRQ_HALF],
                                    vec_table[IRQ_COUNT-1:IRQ_HALF]);
    assign enc_vec_lo = encode_half(irq_masked[IRQ_HALF-1:0],
                                    vec_table[IRQ_HALF-1:0]);

    // Stage 2, results registered into the interface
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half.vec_hi   <= '0;
            half.vec_lo   <= '0;
            half.valid_hi <= 1'b0;
            half.valid_lo <= 1'b0;
        end else begin
            half.vec_hi   <= enc_vec_hi;
            half.vec_lo   <= enc_vec_lo;
            half.valid_hi <= |irq_masked[IRQ_COUNT-1:IRQ_HALF];
            half.valid_lo <= |irq_masked[IRQ_HALF-1:0];
        end
    end

endmodule

/* verilog/ivmu_select_stage.sv */
// Interrupt pipeline stage 3: choose between the half results and register the outputs
`timescale 1ns/10ps

module ivmu_select_stage
    import ivmu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    ivmu_half_if.dst half,
    output vec_t     irq_vector,
    output logic     irq_valid
);

    // Selected vector before the output register
    vec_t sel_vec;

    // Upper half has priority whenever it holds a request
    always_comb begin
        if (half.valid_hi) begin
            sel_vec = half.vec_hi;
        end else if (half.valid_lo) begin
            sel_vec = half.vec_lo;
        end else begin
            // Nothing pending
            sel_vec = '0;
        end
    end

    // Output register, levels only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_vector <= '0;
            irq_valid  <= 1'b0;
        end else begin
            irq_vector <= sel_vec;
            irq_valid  <= half.valid_hi | half.valid_lo;
        end
    end

endmodule

/* verilog/ivmu_top.sv */
// Top level of the interrupt vector unit, wiring the register bank to the three-stage pipeline
`timescale 1ns/10ps

module ivmu_top
    import ivmu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // Register bus
    input  logic              req,
    input  logic              wr,
    input  logic [ADDR_W-1:0] addr,
    input  vec_t              wdata,
    output logic              ack,
    output vec_t              rdata,
    // Interrupt sources and result
    input  irq_t              irq_sources,
    output vec_t              irq_vector,
    output logic              irq_valid
);

    // Configuration from the register bank
    vec_table_t vec_table;
    irq_t       irq_mask;

    // Stage 1 pattern returned for the status register
    irq_t       irq_masked;

    // Stage 2 to stage 3 results
    ivmu_half_if half_bus ();

    ivmu_csr_bank csr_bank_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .wr         (wr),
        .addr       (addr),
        .wdata      (wdata),
        .ack        (ack),
        .rdata      (rdata),
        .irq_masked (irq_masked),
        .vec_table  (vec_table),
        .irq_mask   (irq_mask)
    );

    ivmu_prio_stage prio_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_sources (irq_sources),
        .irq_mask    (irq_mask),
        .vec_table   (vec_table),
        .irq_masked  (irq_masked),
        .half        (half_bus.src)
    );

    ivmu_select_stage select_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .half       (half_bus.dst),
        .irq_vector (irq_vector),
        .irq_valid  (irq_valid)
    );

endmodule
